// File: include/axis_shaper_defs.svh
/*
 * axis_shaper widths
 * fixed datapath, rate and counter sizes shared by the whole shaper
 */

`ifndef AXIS_SHAPER_DEFS_SVH
`define AXIS_SHAPER_DEFS_SVH

// stream payload
`define AXIS_DATA_WIDTH 64
`define AXIS_KEEP_WIDTH 8

// rate fraction num/denom, both 8 bit
`define RATE_WIDTH 8

// credit accumulator, wide enough for long frames in frame mode
`define ACC_WIDTH 24

// traffic statistics counters
`define STAT_WIDTH 32

`endif

// File: src/axis_shaper_pkg.sv
/*
 * axis_shaper types
 * register map addresses and frame tracking state
 */

package axis_shaper_pkg;

    // register port address map
    typedef enum logic [2:0] {
        CFG_RATE_NUM    = 3'd0,
        CFG_RATE_DENOM  = 3'd1,
        CFG_MODE        = 3'd2,
        CFG_STAT_BEATS  = 3'd3,
        CFG_STAT_FRAMES = 3'd4
    } cfg_addr_e;

    // idle: between frames, body: at least one beat of a frame has passed
    typedef enum logic {
        FRAME_IDLE = 1'b0,
        FRAME_BODY = 1'b1
    } frame_state_e;

endpackage

// File: src/axis_skid_reg.sv
/*
 * axis skid register
 * output register plus one temp slot, so that the ready toward the
 * core can be a flop and still lose no beat under back-pressure
 */

`include "axis_shaper_defs.svh"

module axis_skid_reg (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`AXIS_DATA_WIDTH-1:0] int_tdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0] int_tkeep,
    input  logic                        int_tvalid,
    output logic                        int_ready,
    input  logic                        int_tlast,
    input  logic                        int_tuser,
    output logic [`AXIS_DATA_WIDTH-1:0] m_tdata,
    output logic [`AXIS_KEEP_WIDTH-1:0] m_tkeep,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic                        m_tlast,
    output logic                        m_tuser
);

    // temp slot
    logic [`AXIS_DATA_WIDTH-1:0] temp_tdata;
    logic [`AXIS_KEEP_WIDTH-1:0] temp_tkeep;
    logic                        temp_tvalid;
    logic                        temp_tlast;
    logic                        temp_tuser;

    // output slot is free this cycle, either draining or empty
    logic out_free;
    // which slot takes a value at the next edge
    logic load_out_from_int;
    logic load_out_from_temp;
    logic load_temp;

    assign out_free           = m_tready || !m_tvalid;
    assign load_out_from_int  = int_ready && out_free;
    assign load_out_from_temp = !int_ready && m_tready;
    assign load_temp          = int_ready && !out_free && int_tvalid;

    // control flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            int_ready   <= 1'b0;
            m_tvalid    <= 1'b0;
            temp_tvalid <= 1'b0;
        end else begin
            // sink ready passes on with one cycle delay
            // an empty output with nothing arriving can also take a beat
            int_ready <= m_tready || (!m_tvalid && !int_tvalid);

            if (load_out_from_int) begin
                m_tvalid <= int_tvalid;
            end else if (load_out_from_temp) begin
                // temp moves up, empty temp just leaves the output empty
                m_tvalid    <= temp_tvalid;
                temp_tvalid <= 1'b0;
            end

            if (load_temp) begin
                temp_tvalid <= 1'b1;
            end
        end
    end

    // payload, qualified by the flags above
    always_ff @(posedge clk) begin
        if (load_out_from_int) begin
            m_tdata <= int_tdata;
            m_tkeep <= int_tkeep;
            m_tlast <= int_tlast;
            m_tuser <= int_tuser;
        end else if (load_out_from_temp) begin
            m_tdata <= temp_tdata;
            m_tkeep <= temp_tkeep;
            m_tlast <= temp_tlast;
            m_tuser <= temp_tuser;
        end

        if (load_temp) begin
            temp_tdata <= int_tdata;
            temp_tkeep <= int_tkeep;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

    // core must never push a beat into a stalled output while temp is taken
    a_temp_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        int_ready && int_tvalid && m_tvalid && !m_tready |-> !temp_tvalid)
        else $error("skid temp slot overwritten while full");

    // stalled output keeps its beat
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid
            && $stable(m_tdata) && $stable(m_tkeep) && $stable(m_tlast) && $stable(m_tuser))
        else $error("output beat changed under back-pressure");

endmodule

// File: src/rate_limit_core.sv
/*
 * rate limit core
 * credit accumulator that holds throughput to rate_num/rate_denom beats
 * per cycle, with pauses kept to frame boundaries in frame mode
 */

`include "axis_shaper_defs.svh"

module rate_limit_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`AXIS_DATA_WIDTH-1:0] s_tdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0] s_tkeep,
    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic                        s_tlast,
    input  logic                        s_tuser,
    output logic [`AXIS_DATA_WIDTH-1:0] int_tdata,
    output logic [`AXIS_KEEP_WIDTH-1:0] int_tkeep,
    output logic                        int_tvalid,
    input  logic                        int_ready,
    output logic                        int_tlast,
    output logic                        int_tuser,
    input  logic [`RATE_WIDTH-1:0]      rate_num,
    input  logic [`RATE_WIDTH-1:0]      rate_denom,
    input  logic                        rate_by_frame
);

    logic [`ACC_WIDTH-1:0] acc;
    logic [`ACC_WIDTH-1:0] acc_next;
    // num and denom-num widened to the accumulator
    logic [`ACC_WIDTH-1:0] num_ext;
    logic [`ACC_WIDTH-1:0] gap_ext;

    axis_shaper_pkg::frame_state_e frame_state;
    axis_shaper_pkg::frame_state_e frame_next;

    logic xfer;
    logic pause;
    logic pause_reg;

    assign num_ext = {{(`ACC_WIDTH - `RATE_WIDTH){1'b0}}, rate_num};
    // denom >= num is kept by the register block, so no underflow
    assign gap_ext = {{(`ACC_WIDTH - `RATE_WIDTH){1'b0}}, rate_denom - rate_num};

    // both terms are flops, no path from s_tvalid to s_tready
    assign s_tready = int_ready && !pause_reg;
    assign xfer     = s_tvalid && s_tready;

    always_comb begin
        // pay back num per cycle while credit is owed
        acc_next = acc;
        if (acc >= num_ext) begin
            acc_next = acc - num_ext;
        end
        // each accepted beat owes denom-num
        if (xfer) begin
            acc_next = acc_next + gap_ext;
        end

        // frame tracking on input transfers
        frame_next = frame_state;
        if (xfer) begin
            if (s_tlast) begin
                frame_next = axis_shaper_pkg::FRAME_IDLE;
            end else begin
                frame_next = axis_shaper_pkg::FRAME_BODY;
            end
        end

        // stall while credit is owed
        // in frame mode only between frames
        pause = 1'b0;
        if (acc_next >= num_ext) begin
            if (rate_by_frame) begin
                pause = (frame_next == axis_shaper_pkg::FRAME_IDLE);
            end else begin
                pause = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc         <= '0;
            frame_state <= axis_shaper_pkg::FRAME_IDLE;
            pause_reg   <= 1'b0;
        end else begin
            acc         <= acc_next;
            frame_state <= frame_next;
            pause_reg   <= pause;
        end
    end

    // accepted beat goes straight on to the skid register
    assign int_tdata  = s_tdata;
    assign int_tkeep  = s_tkeep;
    assign int_tvalid = xfer;
    assign int_tlast  = s_tlast;
    assign int_tuser  = s_tuser;

    // with frame mode steady, no pause is ever raised in the middle of a frame
    a_no_pause_in_frame: assert property (@(posedge clk) disable iff (rst)
        rate_by_frame && $past(rate_by_frame)
            && frame_state == axis_shaper_pkg::FRAME_BODY |-> !pause_reg)
        else $error("pause raised inside a frame in frame mode");

endmodule

// File: src/shaper_regs.sv
/*
 * shaper register block
 * rate and mode settings with a validity check on rate writes,
 * statistics readback and the statistics clear strobe
 */

`include "axis_shaper_defs.svh"

module shaper_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cfg_wr,
    input  logic                          cfg_rd,
    input  axis_shaper_pkg::cfg_addr_e    cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    output logic [31:0]                   cfg_rdata,
    output logic                          cfg_rvalid,
    input  logic [`STAT_WIDTH-1:0]        stat_beats,
    input  logic [`STAT_WIDTH-1:0]        stat_frames,
    output logic [`RATE_WIDTH-1:0]        rate_num,
    output logic [`RATE_WIDTH-1:0]        rate_denom,
    output logic                          rate_by_frame,
    output logic                          stats_clear
);

    logic [31:0] num_ext;
    logic [31:0] denom_ext;
    logic        num_ok;
    logic        denom_ok;
    logic [31:0] rd_mux;

    assign num_ext   = {{(32 - `RATE_WIDTH){1'b0}}, rate_num};
    assign denom_ext = {{(32 - `RATE_WIDTH){1'b0}}, rate_denom};

    // new num must be nonzero and not above current denom
    assign num_ok   = (cfg_wdata != 32'd0) && (cfg_wdata <= denom_ext);
    // new denom must fit the field and not drop below current num
    assign denom_ok = ((cfg_wdata >> `RATE_WIDTH) == 32'd0) && (cfg_wdata >= num_ext);

    always_comb begin
        case (cfg_addr)
            axis_shaper_pkg::CFG_RATE_NUM:    rd_mux = num_ext;
            axis_shaper_pkg::CFG_RATE_DENOM:  rd_mux = denom_ext;
            axis_shaper_pkg::CFG_MODE:        rd_mux = {31'd0, rate_by_frame};
            axis_shaper_pkg::CFG_STAT_BEATS:  rd_mux = stat_beats;
            axis_shaper_pkg::CFG_STAT_FRAMES: rd_mux = stat_frames;
            default:                          rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // full rate after reset
            rate_num      <= `RATE_WIDTH'(1);
            rate_denom    <= `RATE_WIDTH'(1);
            rate_by_frame <= 1'b0;
            stats_clear   <= 1'b0;
            cfg_rvalid    <= 1'b0;
        end else begin
            stats_clear <= 1'b0;
            cfg_rvalid  <= cfg_rd;
            if (cfg_wr) begin
                case (cfg_addr)
                    axis_shaper_pkg::CFG_RATE_NUM: begin
                        if (num_ok) begin
                            rate_num <= cfg_wdata[`RATE_WIDTH-1:0];
                        end
                    end
                    axis_shaper_pkg::CFG_RATE_DENOM: begin
                        if (denom_ok) begin
                            rate_denom <= cfg_wdata[`RATE_WIDTH-1:0];
                        end
                    end
                    axis_shaper_pkg::CFG_MODE: rate_by_frame <= cfg_wdata[0];
                    // any write to a counter clears both
                    axis_shaper_pkg::CFG_STAT_BEATS,
                    axis_shaper_pkg::CFG_STAT_FRAMES: stats_clear <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // read data, qualified by cfg_rvalid
    always_ff @(posedge clk) begin
        if (cfg_rd) begin
            cfg_rdata <= rd_mux;
        end
    end

    a_rate_valid: assert property (@(posedge clk) disable iff (rst)
        rate_num != '0 && rate_num <= rate_denom)
        else $error("rate setting outside 1 <= num <= denom");

endmodule

// File: src/traffic_stats.sv
/*
 * traffic statistics
 * saturating counters of output beats and completed frames
 */

`include "axis_shaper_defs.svh"

module traffic_stats (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   m_tvalid,
    input  logic                   m_tready,
    input  logic                   m_tlast,
    input  logic                   stats_clear,
    output logic [`STAT_WIDTH-1:0] stat_beats,
    output logic [`STAT_WIDTH-1:0] stat_frames
);

    axis_shaper_pkg::frame_state_e frame_state;
    axis_shaper_pkg::frame_state_e frame_next;

    logic xfer;
    // frame was already running at the last clear, its tail is not a whole frame
    logic skip_partial;

    assign xfer = m_tvalid && m_tready;

    always_comb begin
        frame_next = frame_state;
        if (xfer) begin
            if (m_tlast) begin
                frame_next = axis_shaper_pkg::FRAME_IDLE;
            end else begin
                frame_next = axis_shaper_pkg::FRAME_BODY;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stat_beats   <= '0;
            stat_frames  <= '0;
            frame_state  <= axis_shaper_pkg::FRAME_IDLE;
            skip_partial <= 1'b0;
        end else begin
            frame_state <= frame_next;
            if (stats_clear) begin
                stat_beats   <= '0;
                stat_frames  <= '0;
                skip_partial <= (frame_next == axis_shaper_pkg::FRAME_BODY);
            end else if (xfer) begin
                // hold at all ones
                if (stat_beats != '1) begin
                    stat_beats <= stat_beats + 1'b1;
                end
                if (m_tlast) begin
                    skip_partial <= 1'b0;
                    if (!skip_partial && stat_frames != '1) begin
                        stat_frames <= stat_frames + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: src/axis_shaper_top.sv
/*
 * axis_shaper top level
 * 64 bit AXI4-Stream traffic shaper: rate limit core, skid register,
 * register block and output statistics
 */

`include "axis_shaper_defs.svh"

module axis_shaper_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`AXIS_DATA_WIDTH-1:0] s_tdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0] s_tkeep,
    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic                        s_tlast,
    input  logic                        s_tuser,
    output logic [`AXIS_DATA_WIDTH-1:0] m_tdata,
    output logic [`AXIS_KEEP_WIDTH-1:0] m_tkeep,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic                        m_tlast,
    output logic                        m_tuser,
    input  logic                        cfg_wr,
    input  logic                        cfg_rd,
    input  axis_shaper_pkg::cfg_addr_e  cfg_addr,
    input  logic [31:0]                 cfg_wdata,
    output logic [31:0]                 cfg_rdata,
    output logic                        cfg_rvalid
);

    // settings from the register block
    logic [`RATE_WIDTH-1:0] rate_num;
    logic [`RATE_WIDTH-1:0] rate_denom;
    logic                   rate_by_frame;
    logic                   stats_clear;

    // statistics back to the register block
    logic [`STAT_WIDTH-1:0] stat_beats;
    logic [`STAT_WIDTH-1:0] stat_frames;

    // core to skid register
    logic [`AXIS_DATA_WIDTH-1:0] int_tdata;
    logic [`AXIS_KEEP_WIDTH-1:0] int_tkeep;
    logic                        int_tvalid;
    logic                        int_ready;
    logic                        int_tlast;
    logic                        int_tuser;

    shaper_regs shaper_regs_inst (
        .clk           (clk),
        .rst           (rst),
        .cfg_wr        (cfg_wr),
        .cfg_rd        (cfg_rd),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .cfg_rvalid    (cfg_rvalid),
        .stat_beats    (stat_beats),
        .stat_frames   (stat_frames),
        .rate_num      (rate_num),
        .rate_denom    (rate_denom),
        .rate_by_frame (rate_by_frame),
        .stats_clear   (stats_clear)
    );

    rate_limit_core rate_limit_core_inst (
        .clk           (clk),
        .rst           (rst),
        .s_tdata       (s_tdata),
        .s_tkeep       (s_tkeep),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .s_tlast       (s_tlast),
        .s_tuser       (s_tuser),
        .int_tdata     (int_tdata),
        .int_tkeep     (int_tkeep),
        .int_tvalid    (int_tvalid),
        .int_ready     (int_ready),
        .int_tlast     (int_tlast),
        .int_tuser     (int_tuser),
        .rate_num      (rate_num),
        .rate_denom    (rate_denom),
        .rate_by_frame (rate_by_frame)
    );

    axis_skid_reg axis_skid_reg_inst (
        .clk        (clk),
        .rst        (rst),
        .int_tdata  (int_tdata),
        .int_tkeep  (int_tkeep),
        .int_tvalid (int_tvalid),
        .int_ready  (int_ready),
        .int_tlast  (int_tlast),
        .int_tuser  (int_tuser),
        .m_tdata    (m_tdata),
        .m_tkeep    (m_tkeep),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tlast    (m_tlast),
        .m_tuser    (m_tuser)
    );

    // counts what the sink actually takes
    traffic_stats traffic_stats_inst (
        .clk         (clk),
        .rst         (rst),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .stats_clear (stats_clear),
        .stat_beats  (stat_beats),
        .stat_frames (stat_frames)
    );

endmodule

// File: sim/tb_axis_shaper.sv
/*
 * axis_shaper testbench
 * table of rate settings and traffic shapes applied in turn with a random source,
 * a random-ready sink, a scoreboard queue, an output rate window and register readback
 */

`include "axis_shaper_defs.svh"

module tb_axis_shaper;

    // one row of the stimulus table
    typedef struct packed {
        int num;
        int denom;
        int mode;
        int frame_len;
        int frames;
        int ready_pct;
    } test_entry_t;

    // beat as kept by the scoreboard
    typedef struct packed {
        logic [`AXIS_DATA_WIDTH-1:0] data;
        logic [`AXIS_KEEP_WIDTH-1:0] keep;
        logic                        last;
        logic                        user;
    } beat_t;

    localparam int NUM_TESTS    = 9;
    localparam int RATE_WINDOW  = 400;
    // rate window opens once the source has settled
    localparam int WINDOW_START = 40;

    logic                        clk = 1'b0;
    logic                        rst;
    logic [`AXIS_DATA_WIDTH-1:0] s_tdata;
    logic [`AXIS_KEEP_WIDTH-1:0] s_tkeep;
    logic                        s_tvalid;
    logic                        s_tready;
    logic                        s_tlast;
    logic                        s_tuser;
    logic [`AXIS_DATA_WIDTH-1:0] m_tdata;
    logic [`AXIS_KEEP_WIDTH-1:0] m_tkeep;
    logic                        m_tvalid;
    logic                        m_tready;
    logic                        m_tlast;
    logic                        m_tuser;
    logic                        cfg_wr;
    logic                        cfg_rd;
    axis_shaper_pkg::cfg_addr_e  cfg_addr;
    logic [31:0]                 cfg_wdata;
    logic [31:0]                 cfg_rdata;
    logic                        cfg_rvalid;

    test_entry_t tests [NUM_TESTS];
    // accepted input beats not yet seen at the output
    beat_t       exp_q [$];
    integer      seed = 32'hb546d9cd;
    int          cycle_count = 0;
    int          deadline = 2000;
    // output transfers and tlast transfers since the last statistics clear
    int          out_beats;
    int          out_frames;

    axis_shaper_top axis_shaper_top_inst (
        .clk        (clk),
        .rst        (rst),
        .s_tdata    (s_tdata),
        .s_tkeep    (s_tkeep),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_tlast    (s_tlast),
        .s_tuser    (s_tuser),
        .m_tdata    (m_tdata),
        .m_tkeep    (m_tkeep),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tlast    (m_tlast),
        .m_tuser    (m_tuser),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid)
    );

    always #50 clk = ~clk;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s (got %0h, expected %0h)",
                     $time, msg, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic write_reg(input axis_shaper_pkg::cfg_addr_e addr, input logic [31:0] data);
        @(negedge clk);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    // read data comes with a one-cycle valid pulse one cycle after the strobe
    task automatic expect_reg(input axis_shaper_pkg::cfg_addr_e addr,
                              input logic [31:0] expected, input string msg);
        @(negedge clk);
        cfg_rd   = 1'b1;
        cfg_addr = addr;
        @(negedge clk);
        cfg_rd = 1'b0;
        check_value(cfg_rvalid, 1'b1, "cfg_rvalid missing one cycle after cfg_rd");
        check_value(cfg_rdata, expected, msg);
        @(negedge clk);
        check_value(cfg_rvalid, 1'b0, "cfg_rvalid longer than one cycle");
    endtask

    task automatic apply_rate(input int num, input int denom);
        // widest denom first so that each step keeps 1 <= num <= denom
        write_reg(axis_shaper_pkg::CFG_RATE_DENOM, 255);
        write_reg(axis_shaper_pkg::CFG_RATE_NUM, num);
        write_reg(axis_shaper_pkg::CFG_RATE_DENOM, denom);
        expect_reg(axis_shaper_pkg::CFG_RATE_NUM, num, "rate_num readback");
        expect_reg(axis_shaper_pkg::CFG_RATE_DENOM, denom, "rate_denom readback");
    endtask

    // random payload with tlast closing every frame_len beats
    task automatic present_beat(input int idx, input int frame_len);
        int r;
        s_tdata  = {$random(seed), $random(seed)};
        r        = $random(seed);
        s_tkeep  = r[7:0];
        s_tuser  = r[8];
        s_tlast  = (idx % frame_len) == (frame_len - 1);
        s_tvalid = 1'b1;
    endtask

    task automatic run_stream(input test_entry_t t);
        int    beats;
        int    sent;
        int    received;
        int    cyc;
        int    win_count;
        int    exp_win;
        int    r;
        bit    in_pending;
        bit    in_frame;
        bit    rate_check;
        bit    frame_check;
        beat_t exp_beat;
        beats       = t.frame_len * t.frames;
        sent        = 0;
        received    = 0;
        cyc         = 0;
        win_count   = 0;
        in_pending  = 1'b0;
        in_frame    = 1'b0;
        rate_check  = (t.mode == 0) && (t.ready_pct == 100);
        frame_check = (t.mode == 1) && (t.ready_pct == 100);
        while (received < beats) begin
            @(negedge clk);
            // beat taken at the rising edge just past moves the source on
            if (in_pending) begin
                sent++;
                s_tvalid = 1'b0;
            end
            if (!s_tvalid && sent < beats) begin
                present_beat(sent, t.frame_len);
            end
            r = $random(seed);
            m_tready = ($unsigned(r) % 100) < t.ready_pct;

            // a pending beat inside a frame must never be stalled
            if (frame_check && in_frame && s_tvalid) begin
                check_value(s_tready, 1'b1, "s_tready fell inside a frame in frame mode");
            end

            // handshakes of the coming rising edge use terms that stay stable until then
            in_pending = s_tvalid && s_tready;
            if (in_pending) begin
                exp_q.push_back({s_tdata, s_tkeep, s_tlast, s_tuser});
                in_frame = !s_tlast;
            end
            if (m_tvalid && m_tready) begin
                check_value(exp_q.size() != 0, 1'b1, "output beat with no input beat behind it");
                exp_beat = exp_q.pop_front();
                check_value(m_tdata, exp_beat.data, $sformatf("tdata of beat %0d", received));
                check_value(m_tkeep, exp_beat.keep, $sformatf("tkeep of beat %0d", received));
                check_value(m_tlast, exp_beat.last, $sformatf("tlast of beat %0d", received));
                check_value(m_tuser, exp_beat.user, $sformatf("tuser of beat %0d", received));
                received++;
                out_beats++;
                if (m_tlast) begin
                    out_frames++;
                end
                if (rate_check && cyc >= WINDOW_START && cyc < WINDOW_START + RATE_WINDOW) begin
                    win_count++;
                end
            end
            cyc++;
        end

        // long-term rate is num/denom and the window phase allows +-2
        if (rate_check) begin
            exp_win = RATE_WINDOW * t.num / t.denom;
            check_value(cyc >= WINDOW_START + RATE_WINDOW, 1'b1,
                        "stream ended before the rate window closed");
            check_value((win_count >= exp_win - 2) && (win_count <= exp_win + 2), 1'b1,
                        $sformatf("rate %0d/%0d gave %0d beats in %0d cycles, expected %0d",
                                  t.num, t.denom, win_count, RATE_WINDOW, exp_win));
        end
    endtask

    // budget is set per table entry by the main process
    initial begin : watchdog
        while (cycle_count <= deadline) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout: traffic did not finish within %0d cycles", deadline);
    end

    initial begin
        int beats;
        // num, denom, mode, frame length, frames, sink ready percent
        tests = '{
            '{1, 1, 0, 8, 60, 100},
            '{1, 2, 0, 8, 40, 100},
            '{3, 4, 0, 8, 50, 100},
            '{1, 5, 0, 8, 20, 100},
            '{2, 3, 1, 6, 20, 100},
            '{1, 3, 1, 5, 12, 100},
            '{1, 1, 0, 7, 20, 60},
            '{3, 7, 0, 4, 25, 40},
            '{5, 8, 1, 9, 10, 70}
        };
        rst       = 1'b1;
        s_tdata   = '0;
        s_tkeep   = '0;
        s_tvalid  = 1'b0;
        s_tlast   = 1'b0;
        s_tuser   = 1'b0;
        m_tready  = 1'b1;
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_addr  = axis_shaper_pkg::CFG_RATE_NUM;
        cfg_wdata = '0;

        repeat (2) @(negedge clk);
        check_value(s_tready, 1'b0, "s_tready high in reset");
        check_value(m_tvalid, 1'b0, "m_tvalid high in reset");
        check_value(cfg_rvalid, 1'b0, "cfg_rvalid high in reset");
        rst = 1'b0;

        // reset values give full rate and empty counters
        expect_reg(axis_shaper_pkg::CFG_RATE_NUM, 1, "rate_num after reset");
        expect_reg(axis_shaper_pkg::CFG_RATE_DENOM, 1, "rate_denom after reset");
        expect_reg(axis_shaper_pkg::CFG_MODE, 0, "mode after reset");
        expect_reg(axis_shaper_pkg::CFG_STAT_BEATS, 0, "beat counter after reset");
        expect_reg(axis_shaper_pkg::CFG_STAT_FRAMES, 0, "frame counter after reset");

        // rejected writes keep the previous rate
        apply_rate(3, 4);
        write_reg(axis_shaper_pkg::CFG_RATE_NUM, 0);
        write_reg(axis_shaper_pkg::CFG_RATE_NUM, 5);
        write_reg(axis_shaper_pkg::CFG_RATE_DENOM, 2);
        expect_reg(axis_shaper_pkg::CFG_RATE_NUM, 3, "rate_num after rejected writes");
        expect_reg(axis_shaper_pkg::CFG_RATE_DENOM, 4, "rate_denom after rejected writes");
        // num equal to denom is still valid
        write_reg(axis_shaper_pkg::CFG_RATE_NUM, 4);
        expect_reg(axis_shaper_pkg::CFG_RATE_NUM, 4, "rate_num equal to denom");

        for (int i = 0; i < NUM_TESTS; i++) begin
            beats    = tests[i].frame_len * tests[i].frames;
            deadline = cycle_count + 4 * tests[i].denom * beats / tests[i].num + 1000;
            apply_rate(tests[i].num, tests[i].denom);
            write_reg(axis_shaper_pkg::CFG_MODE, tests[i].mode);
            expect_reg(axis_shaper_pkg::CFG_MODE, tests[i].mode, "mode readback");

            // either counter address clears both
            if (i % 2 == 0) begin
                write_reg(axis_shaper_pkg::CFG_STAT_BEATS, 0);
            end else begin
                write_reg(axis_shaper_pkg::CFG_STAT_FRAMES, 0);
            end
            expect_reg(axis_shaper_pkg::CFG_STAT_BEATS, 0, "beat counter after clear");
            expect_reg(axis_shaper_pkg::CFG_STAT_FRAMES, 0, "frame counter after clear");
            out_beats  = 0;
            out_frames = 0;

            run_stream(tests[i]);

            // nothing may follow the last expected beat
            @(negedge clk);
            m_tready = 1'b1;
            @(negedge clk);
            check_value(m_tvalid, 1'b0, "extra output beat after the last expected one");
            expect_reg(axis_shaper_pkg::CFG_STAT_BEATS, out_beats, "beat counter after traffic");
            expect_reg(axis_shaper_pkg::CFG_STAT_FRAMES, out_frames,
                       "frame counter after traffic");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: axis_shaper.f
+incdir+include
src/axis_shaper_pkg.sv
src/axis_skid_reg.sv
src/rate_limit_core.sv
src/shaper_regs.sv
src/traffic_stats.sv
src/axis_shaper_top.sv
sim/tb_axis_shaper.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the axis_shaper testbench with Verilator and run it
# a $fatal in the testbench gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axis_shaper \
    -f axis_shaper.f \
    --Mdir obj_dir \
    -o tb_axis_shaper

./obj_dir/tb_axis_shaper
